// File: common/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// first instruction fetched after reset
`define RESET_PC   32'h1c00_0000

`define DATA_BASE  32'h1c01_0000  // load/store region, low 12 bits zero for lu12i.w

`endif

// File: common/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;     // data, address and instruction word
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  byte_en_t;
    typedef logic [11:0] alu_op_t;   // one-hot

    // bit positions inside alu_op_t
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    typedef enum logic [1:0] {
        EX_RUN,        // executes one accepted instruction per cycle
        EX_MEM_REQ,
        EX_LOAD_WAIT
    } exec_state_t;

endpackage

`default_nettype wire

// File: common/mem_req_if.sv
`timescale 1ns/10ps
`default_nettype none

interface mem_req_if;
    import cpu_pkg::*;

    logic     req;
    byte_en_t we;
    word_t    addr;
    word_t    wdata;
    logic     gnt;      // transfer cycle
    logic     rvalid;   // one cycle after a read grant
    word_t    rdata;

    modport requester (
        output req, we, addr, wdata,
        input  gnt, rvalid, rdata
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output gnt, rvalid, rdata
    );

endinterface

`default_nettype wire

// File: verilog/mem_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter (
    input  wire                 clk,
    input  wire                 reset,
    mem_req_if.arbiter          fetch_port,
    mem_req_if.arbiter          data_port,
    output logic                mem_en,
    output cpu_pkg::byte_en_t   mem_we,
    output cpu_pkg::word_t      mem_addr,
    output cpu_pkg::word_t      mem_wdata,
    input  wire cpu_pkg::word_t mem_rdata
);

    logic data_gnt;
    logic fetch_gnt;
    logic data_rd_q;    // outstanding read owned by data port
    logic fetch_rd_q;

    // data side always wins
    assign data_gnt  = data_port.req;
    assign fetch_gnt = fetch_port.req & ~data_port.req;

    assign data_port.gnt  = data_gnt;
    assign fetch_port.gnt = fetch_gnt;

    assign mem_en    = data_gnt | fetch_gnt;
    assign mem_we    = data_gnt ? data_port.we : (fetch_gnt ? fetch_port.we : '0);
    assign mem_addr  = data_gnt ? data_port.addr : fetch_port.addr;
    assign mem_wdata = data_gnt ? data_port.wdata : fetch_port.wdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            data_rd_q  <= 1'b0;
            fetch_rd_q <= 1'b0;
        end else begin
            data_rd_q  <= data_gnt & (data_port.we == '0);
            fetch_rd_q <= fetch_gnt & (fetch_port.we == '0);
        end
    end

    assign data_port.rvalid  = data_rd_q;
    assign fetch_port.rvalid = fetch_rd_q;
    assign data_port.rdata   = data_rd_q ? mem_rdata : '0;
    assign fetch_port.rdata  = fetch_rd_q ? mem_rdata : '0;

endmodule

`default_nettype wire

// File: core/fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_settings.svh"

module fetch_stage (
    input  wire                 clk,
    input  wire                 reset,
    mem_req_if.requester        mem,
    input  wire                 br_taken,
    input  wire cpu_pkg::word_t br_target,
    input  wire                 id_allow_in,
    output logic                if_valid,
    output cpu_pkg::word_t      if_pc,
    output cpu_pkg::word_t      if_inst
);
    import cpu_pkg::*;

    word_t pc;          // address of the next fetch
    word_t req_pc;      // address of the read in flight
    logic  in_flight;
    logic  stale;       // in-flight read is wrong path
    logic  buf_valid;
    word_t buf_pc;
    word_t buf_inst;

    // request when buffer is empty or drains this cycle
    assign mem.req   = ~in_flight & (~buf_valid | id_allow_in);
    assign mem.we    = '0;
    assign mem.addr  = pc;
    assign mem.wdata = '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc        <= `RESET_PC;
            in_flight <= 1'b0;
            stale     <= 1'b0;
            buf_valid <= 1'b0;
        end else begin
            if (br_taken) begin
                pc <= br_target;
            end else if (mem.gnt) begin
                pc <= pc + 32'd4;
            end

            if (mem.gnt) begin
                in_flight <= 1'b1;
            end else if (mem.rvalid) begin
                in_flight <= 1'b0;
            end

            if (br_taken && (mem.gnt || (in_flight && !mem.rvalid))) begin
                stale <= 1'b1;
            end else if (mem.rvalid) begin
                stale <= 1'b0;
            end

            if (br_taken) begin
                buf_valid <= 1'b0;   // wrong-path instruction dropped
            end else if (mem.rvalid && !stale) begin
                buf_valid <= 1'b1;
            end else if (id_allow_in) begin
                buf_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem.gnt) begin
            req_pc <= pc;
        end
        if (mem.rvalid && !stale) begin
            buf_pc   <= req_pc;
            buf_inst <= mem.rdata;
        end
    end

    assign if_valid = buf_valid;
    assign if_pc    = buf_pc;
    assign if_inst  = buf_inst;

endmodule

`default_nettype wire

// File: core/decoder.sv
`timescale 1ns/10ps
`default_nettype none

module decoder (
    input  wire cpu_pkg::word_t inst,
    output cpu_pkg::alu_op_t    alu_op,
    output cpu_pkg::reg_idx_t   rj,
    output cpu_pkg::reg_idx_t   rk_or_rd,
    output cpu_pkg::reg_idx_t   dest,
    output cpu_pkg::word_t      imm,
    output cpu_pkg::word_t      br_offs,
    output cpu_pkg::word_t      jirl_offs,
    output logic                src1_is_pc,
    output logic                src2_is_imm,
    output logic                gr_we,
    output logic                mem_we,
    output logic                is_load,
    output logic                is_beq,
    output logic                is_bne,
    output logic                is_jump
);
    import cpu_pkg::*;

    logic op_3r;        // three-register group
    logic op_shift;     // shift by ui5
    logic inst_add_w;
    logic inst_addi_w;
    logic inst_jirl;
    logic inst_b;
    logic inst_bl;

    assign op_3r       = (inst[31:20] == 12'h001);
    assign op_shift    = (inst[31:20] == 12'h004);
    assign inst_add_w  = op_3r & (inst[19:15] == 5'h00);
    assign inst_addi_w = (inst[31:22] == 10'h00a);
    assign is_load     = (inst[31:22] == 10'h0a2);
    assign mem_we      = (inst[31:22] == 10'h0a6);   // st.w
    assign inst_jirl   = (inst[31:26] == 6'h13);
    assign inst_b      = (inst[31:26] == 6'h14);
    assign inst_bl     = (inst[31:26] == 6'h15);
    assign is_beq      = (inst[31:26] == 6'h16);
    assign is_bne      = (inst[31:26] == 6'h17);

    assign alu_op[ALU_ADD]  = inst_add_w | inst_addi_w | is_load | mem_we | inst_jirl | inst_bl;
    assign alu_op[ALU_SUB]  = op_3r & (inst[19:15] == 5'h02);
    assign alu_op[ALU_SLT]  = op_3r & (inst[19:15] == 5'h04);
    assign alu_op[ALU_SLTU] = op_3r & (inst[19:15] == 5'h05);
    assign alu_op[ALU_NOR]  = op_3r & (inst[19:15] == 5'h08);
    assign alu_op[ALU_AND]  = op_3r & (inst[19:15] == 5'h09);
    assign alu_op[ALU_OR]   = op_3r & (inst[19:15] == 5'h0a);
    assign alu_op[ALU_XOR]  = op_3r & (inst[19:15] == 5'h0b);
    assign alu_op[ALU_SLL]  = op_shift & (inst[19:15] == 5'h01);
    assign alu_op[ALU_SRL]  = op_shift & (inst[19:15] == 5'h09);
    assign alu_op[ALU_SRA]  = op_shift & (inst[19:15] == 5'h11);
    assign alu_op[ALU_LUI]  = (inst[31:26] == 6'h05) & ~inst[25];

    assign is_jump     = inst_jirl | inst_b | inst_bl;
    assign src1_is_pc  = inst_jirl | inst_bl;    // link value is pc + 4
    assign src2_is_imm = op_shift | inst_addi_w | is_load | mem_we | alu_op[ALU_LUI]
                       | inst_jirl | inst_bl;
    assign gr_we       = ~mem_we & ~is_beq & ~is_bne & ~inst_b;

    assign rj       = inst[9:5];
    assign rk_or_rd = (is_beq | is_bne | mem_we) ? inst[4:0] : inst[14:10];
    assign dest     = inst_bl ? 5'd1 : inst[4:0];

    assign imm = src1_is_pc      ? 32'd4 :
                 alu_op[ALU_LUI] ? {inst[24:5], 12'b0} :
                                   {{20{inst[21]}}, inst[21:10]};   // si12, also ui5

    assign br_offs   = (inst_b | inst_bl) ? {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0}
                                          : {{14{inst[25]}}, inst[25:10], 2'b0};
    assign jirl_offs = {{14{inst[25]}}, inst[25:10], 2'b0};

endmodule

`default_nettype wire

// File: core/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  wire cpu_pkg::alu_op_t alu_op,
    input  wire cpu_pkg::word_t   src1,
    input  wire cpu_pkg::word_t   src2,
    output cpu_pkg::word_t        result
);
    import cpu_pkg::*;

    logic  use_sub;
    word_t adder_b;
    word_t adder_sum;
    logic  adder_cout;
    logic  slt_res;
    logic  sltu_res;
    word_t sra_res;

    // compares share the subtractor
    assign use_sub = alu_op[ALU_SUB] | alu_op[ALU_SLT] | alu_op[ALU_SLTU];
    assign adder_b = use_sub ? ~src2 : src2;
    assign {adder_cout, adder_sum} = {1'b0, src1} + {1'b0, adder_b} + {32'd0, use_sub};

    assign slt_res  = (src1[31] & ~src2[31]) | (~(src1[31] ^ src2[31]) & adder_sum[31]);
    assign sltu_res = ~adder_cout;   // borrow out
    assign sra_res  = word_t'($signed(src1) >>> src2[4:0]);

    assign result = ({32{alu_op[ALU_ADD] | alu_op[ALU_SUB]}} & adder_sum)
                  | ({32{alu_op[ALU_SLT]}}  & {31'd0, slt_res})
                  | ({32{alu_op[ALU_SLTU]}} & {31'd0, sltu_res})
                  | ({32{alu_op[ALU_AND]}}  & (src1 & src2))
                  | ({32{alu_op[ALU_NOR]}}  & ~(src1 | src2))
                  | ({32{alu_op[ALU_OR]}}   & (src1 | src2))
                  | ({32{alu_op[ALU_XOR]}}  & (src1 ^ src2))
                  | ({32{alu_op[ALU_SLL]}}  & (src1 << src2[4:0]))
                  | ({32{alu_op[ALU_SRL]}}  & (src1 >> src2[4:0]))
                  | ({32{alu_op[ALU_SRA]}}  & sra_res)
                  | ({32{alu_op[ALU_LUI]}}  & src2);   // imm already shifted

endmodule

`default_nettype wire

// File: core/exec_stage.sv
`timescale 1ns/10ps
`default_nettype none

module exec_stage (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 if_valid,
    input  wire cpu_pkg::word_t if_pc,
    input  wire cpu_pkg::word_t if_inst,
    output logic                id_allow_in,
    output logic                br_taken,
    output cpu_pkg::word_t      br_target,
    mem_req_if.requester        mem,
    output cpu_pkg::word_t      debug_wb_pc,
    output cpu_pkg::byte_en_t   debug_wb_rf_we,
    output cpu_pkg::reg_idx_t   debug_wb_rf_wnum,
    output cpu_pkg::word_t      debug_wb_rf_wdata
);
    import cpu_pkg::*;

    exec_state_t state;
    logic        ex_valid;
    word_t       ex_pc;
    word_t       ex_inst;

    alu_op_t  alu_op;
    reg_idx_t rj;
    reg_idx_t rk_or_rd;
    reg_idx_t dest;
    word_t    imm;
    word_t    br_offs;
    word_t    jirl_offs;
    logic     src1_is_pc;
    logic     src2_is_imm;
    logic     gr_we;
    logic     is_store;
    logic     is_load;
    logic     is_beq;
    logic     is_bne;
    logic     is_jump;

    word_t    rf [32];
    word_t    rj_value;
    word_t    rkd_value;
    word_t    alu_src1;
    word_t    alu_src2;
    word_t    alu_result;
    logic     run_fire;     // instruction executes this cycle
    logic     is_jirl;
    logic     accept;
    logic     ld_done;
    logic     rf_we;
    reg_idx_t rf_waddr;
    word_t    rf_wdata;

    word_t    mem_addr_q;
    word_t    mem_wdata_q;
    reg_idx_t mem_dest_q;
    word_t    mem_pc_q;
    logic     mem_store_q;

    decoder u_decoder (
        .inst        (ex_inst),
        .alu_op      (alu_op),
        .rj          (rj),
        .rk_or_rd    (rk_or_rd),
        .dest        (dest),
        .imm         (imm),
        .br_offs     (br_offs),
        .jirl_offs   (jirl_offs),
        .src1_is_pc  (src1_is_pc),
        .src2_is_imm (src2_is_imm),
        .gr_we       (gr_we),
        .mem_we      (is_store),
        .is_load     (is_load),
        .is_beq      (is_beq),
        .is_bne      (is_bne),
        .is_jump     (is_jump)
    );

    assign rj_value  = (rj == '0) ? '0 : rf[rj];
    assign rkd_value = (rk_or_rd == '0) ? '0 : rf[rk_or_rd];
    assign alu_src1  = src1_is_pc ? ex_pc : rj_value;
    assign alu_src2  = src2_is_imm ? imm : rkd_value;

    alu u_alu (
        .alu_op (alu_op),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result)
    );

    assign run_fire  = (state == EX_RUN) & ex_valid;
    assign is_jirl   = (ex_inst[31:26] == 6'h13);
    assign br_taken  = run_fire & ((is_beq & (rj_value == rkd_value))
                                 | (is_bne & (rj_value != rkd_value))
                                 | is_jump);
    assign br_target = is_jirl ? rj_value + jirl_offs : ex_pc + br_offs;

    // hold off fetch on redirects and memory ops
    assign id_allow_in = (state == EX_RUN) & ~br_taken & ~(run_fire & (is_load | is_store));
    assign accept      = if_valid & id_allow_in;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= EX_RUN;
            ex_valid <= 1'b0;
        end else begin
            case (state)
                EX_RUN: begin
                    ex_valid <= accept;
                    if (run_fire && (is_load || is_store)) begin
                        state <= EX_MEM_REQ;
                    end
                end
                EX_MEM_REQ: begin
                    if (mem.gnt) begin
                        state <= mem_store_q ? EX_RUN : EX_LOAD_WAIT;   // store retires here
                    end
                end
                EX_LOAD_WAIT: begin
                    if (mem.rvalid) begin
                        state <= EX_RUN;
                    end
                end
                default: state <= EX_RUN;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ex_pc   <= if_pc;
            ex_inst <= if_inst;
        end
        if (run_fire && (is_load || is_store)) begin
            mem_addr_q  <= alu_result;
            mem_wdata_q <= rkd_value;
            mem_dest_q  <= dest;
            mem_pc_q    <= ex_pc;
            mem_store_q <= is_store;
        end
    end

    assign mem.req   = (state == EX_MEM_REQ);
    assign mem.we    = mem_store_q ? '1 : '0;
    assign mem.addr  = mem_addr_q;
    assign mem.wdata = mem_wdata_q;

    assign ld_done  = (state == EX_LOAD_WAIT) & mem.rvalid;
    assign rf_we    = (run_fire & gr_we & ~is_load) | ld_done;
    assign rf_waddr = ld_done ? mem_dest_q : dest;
    assign rf_wdata = ld_done ? mem.rdata : alu_result;

    always_ff @(posedge clk) begin
        if (rf_we && rf_waddr != '0) begin
            rf[rf_waddr] <= rf_wdata;
        end
    end

    assign debug_wb_pc       = ld_done ? mem_pc_q : ex_pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = rf_waddr;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

`default_nettype wire

// File: verilog/cpu_top.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_top (
    input  wire                 clk,
    input  wire                 reset,
    output logic                mem_en,
    output cpu_pkg::byte_en_t   mem_we,
    output cpu_pkg::word_t      mem_addr,
    output cpu_pkg::word_t      mem_wdata,
    input  wire cpu_pkg::word_t mem_rdata,
    output cpu_pkg::word_t      debug_wb_pc,
    output cpu_pkg::byte_en_t   debug_wb_rf_we,
    output cpu_pkg::reg_idx_t   debug_wb_rf_wnum,
    output cpu_pkg::word_t      debug_wb_rf_wdata
);
    import cpu_pkg::*;

    logic  if_valid;
    word_t if_pc;
    word_t if_inst;
    logic  id_allow_in;
    logic  br_taken;      // one-cycle redirect
    word_t br_target;

    mem_req_if fetch_mem ();
    mem_req_if data_mem ();

    fetch_stage u_fetch (
        .clk         (clk),
        .reset       (reset),
        .mem         (fetch_mem),
        .br_taken    (br_taken),
        .br_target   (br_target),
        .id_allow_in (id_allow_in),
        .if_valid    (if_valid),
        .if_pc       (if_pc),
        .if_inst     (if_inst)
    );

    exec_stage u_exec (
        .clk               (clk),
        .reset             (reset),
        .if_valid          (if_valid),
        .if_pc             (if_pc),
        .if_inst           (if_inst),
        .id_allow_in       (id_allow_in),
        .br_taken          (br_taken),
        .br_target         (br_target),
        .mem               (data_mem),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    mem_arbiter u_arbiter (
        .clk        (clk),
        .reset      (reset),
        .fetch_port (fetch_mem),
        .data_port  (data_mem),
        .mem_en     (mem_en),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata)
    );

endmodule

`default_nettype wire

// File: testbench/cpu_assert.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_settings.svh"

module cpu_assert (
    input wire                       clk,
    input wire                       reset,
    input wire                       data_gnt,
    input wire                       fetch_gnt,
    input wire                       data_rvalid,
    input wire                       fetch_rvalid,
    input wire                       mem_en,
    input wire cpu_pkg::byte_en_t    mem_we,
    input wire cpu_pkg::word_t       mem_addr,
    input wire cpu_pkg::byte_en_t    wb_we,
    input wire cpu_pkg::exec_state_t state
);
    import cpu_pkg::*;

    a_one_grant: assert property (@(posedge clk) disable iff (reset) !(data_gnt && fetch_gnt))
        else $error("both requesters granted");

    a_we_needs_en: assert property (@(posedge clk) disable iff (reset) (mem_we != '0) |-> mem_en)
        else $error("mem_we without mem_en");

    a_data_rvalid: assert property (@(posedge clk) disable iff (reset)
        data_rvalid |-> $past(data_gnt && mem_we == '0))
        else $error("data rvalid without read grant");

    a_fetch_rvalid: assert property (@(posedge clk) disable iff (reset)
        fetch_rvalid |-> $past(fetch_gnt && mem_we == '0))
        else $error("fetch rvalid without read grant");

    // stores stay in the data region
    a_store_region: assert property (@(posedge clk) disable iff (reset)
        (mem_we != '0) |-> (mem_addr >= `DATA_BASE && mem_addr < `DATA_BASE + 32'd64))
        else $error("store outside data region");

    a_reset_quiet: assert property (@(posedge clk) $past(reset) |-> (wb_we == '0 && state == EX_RUN))
        else $error("writeback or busy exec after reset");

endmodule

bind cpu_top cpu_assert u_cpu_assert (
    .clk          (clk),
    .reset        (reset),
    .data_gnt     (u_arbiter.data_gnt),
    .fetch_gnt    (u_arbiter.fetch_gnt),
    .data_rvalid  (u_arbiter.data_rd_q),
    .fetch_rvalid (u_arbiter.fetch_rd_q),
    .mem_en       (mem_en),
    .mem_we       (mem_we),
    .mem_addr     (mem_addr),
    .wb_we        (debug_wb_rf_we),
    .state        (u_exec.state)
);

`default_nettype wire

// File: testbench/cpu_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_settings.svh"

module cpu_tb;

    localparam int NUM_PROGS  = 4;
    localparam int PROG_LEN   = 60;
    localparam int DATA_WORDS = 16;
    localparam time WATCHDOG  = 200 * PROG_LEN * NUM_PROGS * 20ns;

    logic        clk;
    logic        reset;
    logic        mem_en;
    logic [3:0]  mem_we;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] lfsr_state = 32'd82;
    logic [31:0] prog [PROG_LEN];
    logic [31:0] mem [int unsigned];        // word addressed
    logic [31:0] model_mem [int unsigned];
    logic [31:0] exp_pc [$];
    logic [4:0]  exp_num [$];
    logic [31:0] exp_data [$];
    logic [31:0] exp_st_addr [$];
    logic [31:0] exp_st_data [$];
    logic        rd_pending;
    logic [31:0] rd_addr;
    logic        loop_seen;
    int          errors = 0;

    cpu_top UUT (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'hb4bc_d35c) : (lfsr_state >> 1);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return a ^ 32'hc3a5_96e1 ^ {a[15:0], a[31:16]};
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // encoders
    function automatic logic [31:0] enc_3r(input logic [16:0] op, input logic [4:0] rk,
                                           input logic [4:0] rj, input logic [4:0] rd);
        return {op, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_i12(input logic [9:0] op, input logic [11:0] im,
                                            input logic [4:0] rj, input logic [4:0] rd);
        return {op, im, rj, rd};
    endfunction

    function automatic logic [31:0] enc_br(input logic [5:0] op, input logic [15:0] offs,
                                           input logic [4:0] rj, input logic [4:0] rd);
        return {op, offs, rj, rd};
    endfunction

    function automatic logic [4:0] pick_dest();
        logic [4:0] d;
        d = rand_bits(3);
        return (d == 5'd2) ? 5'd3 : d;    // r2 holds the data base
    endfunction

    task automatic gen_program();
        int          i;
        int          k;
        int          max_tgt;
        logic [3:0]  kind;
        logic [31:0] tgt;
        logic [4:0]  ops [8];
        ops = '{5'h00, 5'h02, 5'h04, 5'h05, 5'h08, 5'h09, 5'h0a, 5'h0b};
        max_tgt = 0;
        for (int r = 0; r < 6; r++)
            prog[r] = enc_i12(10'h00a, rand_bits(12), 5'd0, (r == 0) ? 5'd1 : 5'(r + 2));
        prog[6] = {7'h0a, 20'(`DATA_BASE >> 12), 5'd2};
        i = 7;
        while (i < PROG_LEN - 1) begin
            kind = rand_bits(4);
            k = rand_bits(2);
            if (kind <= 5) begin
                prog[i] = enc_3r({12'h001, ops[rand_bits(3)]}, rand_bits(3), rand_bits(3),
                                 pick_dest());
            end else if (kind <= 7) begin
                prog[i] = enc_3r({12'h004, (rand_bits(1) ? 5'h09 : (rand_bits(1) ? 5'h11
                                 : 5'h01))}, rand_bits(5), rand_bits(3), pick_dest());
            end else if (kind == 8) begin
                prog[i] = {7'h0a, 20'(rand_bits(20)), pick_dest()};
            end else if (kind == 11) begin
                prog[i] = enc_i12(10'h0a2, rand_bits(4) << 2, 5'd2, pick_dest());
            end else if (kind == 12) begin
                prog[i] = enc_i12(10'h0a6, rand_bits(4) << 2, 5'd2, rand_bits(3));
            end else if (kind == 13) begin
                if (k > PROG_LEN - 2 - i) k = PROG_LEN - 2 - i;
                prog[i] = enc_br(rand_bits(1) ? 6'h16 : 6'h17, 16'(k + 1), rand_bits(3),
                                 rand_bits(3));
                if (i + k + 1 > max_tgt) max_tgt = i + k + 1;
            end else if (kind == 14) begin
                if (k > PROG_LEN - 2 - i) k = PROG_LEN - 2 - i;
                prog[i] = {rand_bits(1) ? 6'h15 : 6'h14, 16'(k + 1), 10'd0};
                if (i + k + 1 > max_tgt) max_tgt = i + k + 1;
            end else if (kind == 15 && i + 3 < PROG_LEN - 1 && max_tgt <= i) begin
                // no branch lands inside the jirl sequence
                if (k > PROG_LEN - 4 - i) k = PROG_LEN - 4 - i;
                tgt = `RESET_PC + 4 * (i + 3 + k);
                prog[i] = {7'h0a, tgt[31:12], 5'd7};
                prog[i + 1] = enc_i12(10'h00a, tgt[11:0], 5'd7, 5'd7);
                prog[i + 2] = enc_br(6'h13, 16'd0, 5'd7, pick_dest());
                if (i + 3 + k > max_tgt) max_tgt = i + 3 + k;
                i += 2;
            end else begin
                prog[i] = enc_i12(10'h00a, rand_bits(12), rand_bits(3), pick_dest());
            end
            i++;
        end
        prog[PROG_LEN - 1] = {6'h14, 26'd0};   // self-loop
    endtask

    function automatic logic [31:0] model_read(input logic [31:0] a);
        return model_mem.exists(a[31:2]) ? model_mem[a[31:2]] : fill_word(a);
    endfunction

    // ISA reference model along the architectural path
    task automatic run_model();
        logic [31:0] rf [32];
        logic [31:0] pc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] si12;
        logic [31:0] offs16;
        logic [31:0] res;
        logic [31:0] next_pc;
        logic        wr;
        logic [4:0]  rd;
        foreach (rf[r]) rf[r] = '0;
        model_mem.delete();
        pc = `RESET_PC;
        for (int step = 0; step < 4 * PROG_LEN; step++) begin
            w = prog[(pc - `RESET_PC) >> 2];
            if (w == {6'h14, 26'd0}) break;
            a = rf[w[9:5]];
            b = rf[w[14:10]];
            si12 = {{20{w[21]}}, w[21:10]};
            offs16 = {{14{w[25]}}, w[25:10], 2'b00};
            rd = w[4:0];
            wr = 1'b1;
            res = '0;
            next_pc = pc + 4;
            if (w[31:20] == 12'h001) begin
                case (w[19:15])
                    5'h00: res = a + b;
                    5'h02: res = a - b;
                    5'h04: res = {31'd0, $signed(a) < $signed(b)};
                    5'h05: res = {31'd0, a < b};
                    5'h08: res = ~(a | b);
                    5'h09: res = a & b;
                    5'h0a: res = a | b;
                    default: res = a ^ b;
                endcase
            end else if (w[31:20] == 12'h004) begin
                case (w[19:15])
                    5'h01: res = a << w[14:10];
                    5'h09: res = a >> w[14:10];
                    default: res = $signed(a) >>> w[14:10];
                endcase
            end else if (w[31:22] == 10'h00a) begin
                res = a + si12;
            end else if (w[31:25] == 7'h0a) begin
                res = {w[24:5], 12'd0};
            end else if (w[31:22] == 10'h0a2) begin
                res = model_read(a + si12);
            end else if (w[31:22] == 10'h0a6) begin
                wr = 1'b0;
                model_mem[(a + si12) >> 2] = rf[rd];
                exp_st_addr.push_back(a + si12);
                exp_st_data.push_back(rf[rd]);
            end else if (w[31:26] == 6'h13) begin
                res = pc + 4;
                next_pc = a + offs16;
            end else if (w[31:26] == 6'h14 || w[31:26] == 6'h15) begin
                wr = w[26];
                rd = 5'd1;
                res = pc + 4;
                next_pc = pc + {{4{w[9]}}, w[9:0], w[25:10], 2'b00};
            end else begin
                wr = 1'b0;
                if ((w[26] == 1'b0) == (a == rf[rd])) next_pc = pc + offs16;
            end
            if (wr) begin
                exp_pc.push_back(pc);
                exp_num.push_back(rd);
                exp_data.push_back(res);
                if (rd != 0) rf[rd] = res;
            end
            pc = next_pc;
        end
    endtask

    // memory model with a one cycle read latency
    always @(posedge clk) begin
        if (reset) begin
            rd_pending <= 1'b0;
        end else begin
            rd_pending <= mem_en && mem_we == 4'd0;
            rd_addr <= mem_addr;
            if (mem_en && mem_we == 4'd0 && mem_addr == `RESET_PC + 4 * (PROG_LEN - 1))
                loop_seen <= 1'b1;
            if (mem_en && mem_we != 4'd0) begin
                if (!mem.exists(mem_addr[31:2])) mem[mem_addr[31:2]] = fill_word(mem_addr);
                for (int b = 0; b < 4; b++)
                    if (mem_we[b]) mem[mem_addr[31:2]][8 * b +: 8] = mem_wdata[8 * b +: 8];
                if (exp_st_addr.size() == 0) begin
                    errors++;
                    $display("store to %h at %0t that the model does not expect", mem_addr, $time);
                end else begin
                    check("mem_we", 32'(mem_we), 32'hf);
                    check("mem_addr", mem_addr, exp_st_addr.pop_front());
                    check("mem_wdata", mem_wdata, exp_st_data.pop_front());
                end
            end
        end
    end

    always @(negedge clk) begin
        if (rd_pending)
            mem_rdata <= mem.exists(rd_addr[31:2]) ? mem[rd_addr[31:2]] : fill_word(rd_addr);
    end

    // writeback monitor
    always @(posedge clk) begin
        if (debug_wb_rf_we != 4'd0) begin
            if (reset) begin
                errors++;
                $display("register write during reset at %0t", $time);
            end else if (exp_pc.size() == 0) begin
                errors++;
                $display("register write at pc %h at %0t that the model does not expect",
                         debug_wb_pc, $time);
            end else begin
                check("debug_wb_rf_we", 32'(debug_wb_rf_we), 32'hf);
                check("debug_wb_pc", debug_wb_pc, exp_pc.pop_front());
                check("debug_wb_rf_wnum", 32'(debug_wb_rf_wnum), 32'(exp_num.pop_front()));
                check("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_data.pop_front());
            end
        end
    end

    initial begin
        #(WATCHDOG);
        $display("watchdog expired, a program did not reach its final loop");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        logic [31:0] a;
        clk = 1'b0;
        reset = 1'b1;
        mem_rdata = '0;
        loop_seen = 1'b0;
        for (int p = 0; p < NUM_PROGS; p++) begin
            @(negedge clk);
            reset = 1'b1;
            gen_program();
            run_model();
            mem.delete();
            for (int i = 0; i < PROG_LEN; i++) mem[(`RESET_PC >> 2) + i] = prog[i];
            loop_seen = 1'b0;
            repeat (3) @(negedge clk);
            reset = 1'b0;
            while (!(loop_seen && exp_pc.size() == 0 && exp_st_addr.size() == 0))
                @(negedge clk);
            repeat (4) @(negedge clk);
            for (int k = 0; k < DATA_WORDS; k++) begin
                a = `DATA_BASE + 4 * k;
                check("data region", mem.exists(a[31:2]) ? mem[a[31:2]] : fill_word(a),
                      model_read(a));
            end
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+common
common/cpu_pkg.sv
common/mem_req_if.sv
verilog/mem_arbiter.sv
core/fetch_stage.sv
core/decoder.sv
core/alu.sv
core/exec_stage.sv
verilog/cpu_top.sv
testbench/cpu_assert.sv
testbench/cpu_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert -Wall
TOP       ?= cpu_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
